// ==== Bender.yml ====
package:
  name: rv32i_exec

sources:
  - src/riscv_pkg.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/instr_decode.sv
  - src/exec_ctrl.sv
  - src/exec_top.sv
  - target: test
    files:
      - verif/exec_sva.sv
      - verif/exec_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [riscv_pkg::xlen-1:0] a,
    input  logic [riscv_pkg::xlen-1:0] b,
    input  riscv_pkg::alu_op_e         op,
    output logic [riscv_pkg::xlen-1:0] res,
    output riscv_pkg::alu_flags_t      flags
);

    logic [riscv_pkg::xlen-1:0] b_op;
    logic                       cin;
    logic [riscv_pkg::xlen-1:0] sum;
    logic                       co;
    logic                       ov_raw;
    logic                       use_adder;
    logic [4:0]                 shamt;

    // shift amount is the low five bits of b
    assign shamt = b[4:0];

    // sub and both compares go through the inverted b path
    always_comb begin
        case (op)
            riscv_pkg::alu_op_sub,
            riscv_pkg::alu_op_slt,
            riscv_pkg::alu_op_sltu: begin
                b_op = ~b;
                cin  = 1'b1;
            end
            default: begin
                b_op = b;
                cin  = 1'b0;
            end
        endcase
    end

    // single shared adder with carry out
    assign {co, sum} = {1'b0, a} + {1'b0, b_op} + {{riscv_pkg::xlen{1'b0}}, cin};

    // same-sign operands giving a result of the other sign
    assign ov_raw = (a[31] == b_op[31]) && (sum[31] != a[31]);

    always_comb begin
        case (op)
            riscv_pkg::alu_op_add:  res = sum;
            riscv_pkg::alu_op_sub:  res = sum;
            // signed less-than from the difference
            riscv_pkg::alu_op_slt:  res = {31'b0, sum[31] ^ ov_raw};
            // borrow means a < b unsigned
            riscv_pkg::alu_op_sltu: res = {31'b0, ~co};
            riscv_pkg::alu_op_and:  res = a & b;
            riscv_pkg::alu_op_or:   res = a | b;
            riscv_pkg::alu_op_xor:  res = a ^ b;
            riscv_pkg::alu_op_sll:  res = a << shamt;
            riscv_pkg::alu_op_srl:  res = a >> shamt;
            riscv_pkg::alu_op_sra:  res = $unsigned($signed(a) >>> shamt);
            default:                res = '0;
        endcase
    end

    // ops that report the adder carry
    always_comb begin
        case (op)
            riscv_pkg::alu_op_add,
            riscv_pkg::alu_op_sub,
            riscv_pkg::alu_op_slt,
            riscv_pkg::alu_op_sltu: use_adder = 1'b1;
            default:                use_adder = 1'b0;
        endcase
    end

    always_comb begin
        flags          = '0;
        // overflow only meaningful for add and sub
        flags.overflow = ((op == riscv_pkg::alu_op_add) || (op == riscv_pkg::alu_op_sub))
                         && ov_raw;
        flags.carry    = use_adder && co;
        flags.zero     = (res == '0);
        flags.negative = res[31];
        // illegal comes from the controller
        flags.illegal  = 1'b0;
    end

endmodule

// ==== src/exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    // wishbone classic slave
    input  logic                             cyc,
    input  logic                             stb,
    input  logic                             we,
    input  logic [7:0]                       adr,
    input  logic [riscv_pkg::xlen-1:0]       dat_i,
    output logic [riscv_pkg::xlen-1:0]       dat_o,
    output logic                             ack,
    // decoder
    output logic [31:0]                      instr,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs1,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs2,
    input  logic [riscv_pkg::reg_addr_w-1:0] rd,
    input  logic [riscv_pkg::xlen-1:0]       imm,
    input  riscv_pkg::alu_op_e               alu_op,
    input  logic                             use_imm,
    input  logic                             zero_a,
    input  logic                             writes_rd,
    input  logic                             illegal,
    // register file
    output logic [riscv_pkg::reg_addr_w-1:0] raddr_a,
    output logic [riscv_pkg::reg_addr_w-1:0] raddr_b,
    input  logic [riscv_pkg::xlen-1:0]       rdata_a,
    input  logic [riscv_pkg::xlen-1:0]       rdata_b,
    output logic                             rf_we,
    output logic [riscv_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [riscv_pkg::xlen-1:0]       rf_wdata,
    // alu
    output logic [riscv_pkg::xlen-1:0]       alu_a,
    output logic [riscv_pkg::xlen-1:0]       alu_b,
    output riscv_pkg::alu_op_e               alu_op_out,
    input  logic [riscv_pkg::xlen-1:0]       alu_res,
    input  riscv_pkg::alu_flags_t            alu_flags
);

    riscv_pkg::exec_state_e     state;
    logic                       instr_op;
    logic [riscv_pkg::xlen-1:0] result_q;
    riscv_pkg::alu_flags_t      flags_q;
    logic [riscv_pkg::xlen-1:0] exec_res;
    riscv_pkg::alu_flags_t      exec_flags;
    logic                       req;
    logic                       wb_reg;
    logic [riscv_pkg::xlen-1:0] rd_data;

    // no new request while the previous ack is still out
    assign req    = cyc && stb && !ack;
    assign wb_reg = adr[7] && !instr_op;

    // wishbone index for bus register access, rs1 while executing
    assign raddr_a = wb_reg ? adr[6:2] : rs1;
    assign raddr_b = rs2;

    // write port, both sources commit in respond
    assign rf_we    = (state == riscv_pkg::st_respond) &&
                      (instr_op ? writes_rd : (wb_reg && we));
    assign rf_waddr = instr_op ? rd : adr[6:2];
    assign rf_wdata = instr_op ? exec_res : dat_i;

    // read data mux for bus reads
    always_comb begin
        if (adr[7]) begin
            rd_data = rdata_a;
        end else begin
            case (adr)
                riscv_pkg::addr_instr:  rd_data = instr;
                riscv_pkg::addr_result: rd_data = result_q;
                riscv_pkg::addr_flags:  rd_data = {27'b0, flags_q};
                default:                rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= riscv_pkg::st_idle;
            ack      <= 1'b0;
            instr_op <= 1'b0;
            instr    <= '0;
            result_q <= '0;
            flags_q  <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                riscv_pkg::st_idle: begin
                    if (req) begin
                        if (we && (adr == riscv_pkg::addr_instr)) begin
                            instr    <= dat_i;
                            instr_op <= 1'b1;
                            state    <= riscv_pkg::st_decode;
                        end else begin
                            state <= riscv_pkg::st_respond;
                        end
                    end
                end
                riscv_pkg::st_decode: begin
                    state <= riscv_pkg::st_execute;
                end
                riscv_pkg::st_execute: begin
                    state <= riscv_pkg::st_respond;
                end
                riscv_pkg::st_respond: begin
                    ack      <= 1'b1;
                    instr_op <= 1'b0;
                    state    <= riscv_pkg::st_idle;
                    if (instr_op) begin
                        if (illegal) begin
                            result_q         <= '0;
                            flags_q          <= '0;
                            flags_q.illegal  <= 1'b1;
                        end else begin
                            result_q <= exec_res;
                            flags_q  <= exec_flags;
                        end
                    end
                end
                default: begin
                    state <= riscv_pkg::st_idle;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == riscv_pkg::st_decode) begin
            alu_a      <= zero_a ? '0 : rdata_a;
            alu_b      <= use_imm ? imm : rdata_b;
            alu_op_out <= alu_op;
        end
        if (state == riscv_pkg::st_execute) begin
            exec_res   <= alu_res;
            exec_flags <= alu_flags;
        end
        if ((state == riscv_pkg::st_respond) && !instr_op && !we) begin
            dat_o <= rd_data;
        end
    end

endmodule

// ==== src/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [7:0]                 adr,
    input  logic [riscv_pkg::xlen-1:0] dat_i,
    // byte lanes ignored, full-word access only
    input  logic [3:0]                 sel,
    output logic [riscv_pkg::xlen-1:0] dat_o,
    output logic                       ack
);

    logic [31:0]                      instr;
    logic [riscv_pkg::reg_addr_w-1:0] rs1;
    logic [riscv_pkg::reg_addr_w-1:0] rs2;
    logic [riscv_pkg::reg_addr_w-1:0] rd;
    logic [riscv_pkg::xlen-1:0]       imm;
    riscv_pkg::alu_op_e               dec_alu_op;
    logic                             use_imm;
    logic                             zero_a;
    logic                             writes_rd;
    logic                             illegal;

    logic [riscv_pkg::reg_addr_w-1:0] raddr_a;
    logic [riscv_pkg::reg_addr_w-1:0] raddr_b;
    logic [riscv_pkg::xlen-1:0]       rdata_a;
    logic [riscv_pkg::xlen-1:0]       rdata_b;
    logic                             rf_we;
    logic [riscv_pkg::reg_addr_w-1:0] rf_waddr;
    logic [riscv_pkg::xlen-1:0]       rf_wdata;

    logic [riscv_pkg::xlen-1:0]       alu_a;
    logic [riscv_pkg::xlen-1:0]       alu_b;
    riscv_pkg::alu_op_e               alu_op;
    logic [riscv_pkg::xlen-1:0]       alu_res;
    riscv_pkg::alu_flags_t            alu_flags;

    exec_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack        (ack),
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .alu_op     (dec_alu_op),
        .use_imm    (use_imm),
        .zero_a     (zero_a),
        .writes_rd  (writes_rd),
        .illegal    (illegal),
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op_out (alu_op),
        .alu_res    (alu_res),
        .alu_flags  (alu_flags)
    );

    instr_decode u_decode (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (dec_alu_op),
        .use_imm   (use_imm),
        .zero_a    (zero_a),
        .writes_rd (writes_rd),
        .illegal   (illegal)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .res   (alu_res),
        .flags (alu_flags)
    );

endmodule

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic [31:0]                      instr,
    output logic [riscv_pkg::reg_addr_w-1:0] rs1,
    output logic [riscv_pkg::reg_addr_w-1:0] rs2,
    output logic [riscv_pkg::reg_addr_w-1:0] rd,
    output logic [riscv_pkg::xlen-1:0]       imm,
    output riscv_pkg::alu_op_e               alu_op,
    output logic                             use_imm,
    output logic                             zero_a,
    output logic                             writes_rd,
    output logic                             illegal
);

    riscv_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    riscv_pkg::alu_op_e funct_op;

    assign opcode = riscv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // funct3 to alu op, funct7[5] picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  funct_op = funct7[5] ? riscv_pkg::alu_op_sub : riscv_pkg::alu_op_add;
            3'b001:  funct_op = riscv_pkg::alu_op_sll;
            3'b010:  funct_op = riscv_pkg::alu_op_slt;
            3'b011:  funct_op = riscv_pkg::alu_op_sltu;
            3'b100:  funct_op = riscv_pkg::alu_op_xor;
            3'b101:  funct_op = funct7[5] ? riscv_pkg::alu_op_sra : riscv_pkg::alu_op_srl;
            3'b110:  funct_op = riscv_pkg::alu_op_or;
            default: funct_op = riscv_pkg::alu_op_and;
        endcase
    end

    always_comb begin
        alu_op    = riscv_pkg::alu_op_add;
        imm       = {{20{instr[31]}}, instr[31:20]};
        use_imm   = 1'b0;
        zero_a    = 1'b0;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            riscv_pkg::opc_op: begin
                alu_op    = funct_op;
                writes_rd = 1'b1;
            end
            riscv_pkg::opc_op_imm: begin
                use_imm   = 1'b1;
                writes_rd = 1'b1;
                // no subi, funct7 only matters for shifts
                if (funct3 == 3'b000) begin
                    alu_op = riscv_pkg::alu_op_add;
                end else begin
                    alu_op = funct_op;
                end
                if ((funct3 == 3'b001 || funct3 == 3'b101) &&
                    (funct7 != 7'h00) && (funct7 != 7'h20)) begin
                    illegal   = 1'b1;
                    writes_rd = 1'b0;
                end
            end
            riscv_pkg::opc_lui: begin
                // 0 + upper immediate
                imm       = {instr[31:12], 12'b0};
                use_imm   = 1'b1;
                zero_a    = 1'b1;
                writes_rd = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [riscv_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [riscv_pkg::reg_addr_w-1:0] raddr_b,
    output logic [riscv_pkg::xlen-1:0]       rdata_a,
    output logic [riscv_pkg::xlen-1:0]       rdata_b,
    input  logic                             we,
    input  logic [riscv_pkg::reg_addr_w-1:0] waddr,
    input  logic [riscv_pkg::xlen-1:0]       wdata
);

    // x0 has no storage
    logic [riscv_pkg::xlen-1:0] regs [1:riscv_pkg::reg_count-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < riscv_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, index 0 is hardwired zero
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

// ==== src/riscv_pkg.sv ====
package riscv_pkg;

    // datapath and register file geometry
    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;

    // instruction write: request sample to ack, in clock edges
    localparam int ack_latency_instr = 3;

    // byte addresses on the wishbone bus
    localparam logic [7:0] addr_instr    = 8'h00;
    localparam logic [7:0] addr_result   = 8'h04;
    localparam logic [7:0] addr_flags    = 8'h08;
    // bit 7 selects the register file, bits 6..2 give the index
    localparam logic [7:0] addr_reg_base = 8'h80;

    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sub  = 4'd1,
        alu_op_slt  = 4'd2,
        alu_op_sltu = 4'd3,
        alu_op_and  = 4'd4,
        alu_op_or   = 4'd5,
        alu_op_xor  = 4'd6,
        alu_op_sll  = 4'd7,
        alu_op_srl  = 4'd8,
        alu_op_sra  = 4'd9
    } alu_op_e;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_decode  = 2'd1,
        st_execute = 2'd2,
        st_respond = 2'd3
    } exec_state_e;

    // read back at addr_flags in bits 4..0, overflow in bit 0
    typedef struct packed {
        logic illegal;
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } alu_flags_t;

endpackage

// ==== tb.f ====
src/riscv_pkg.sv
src/alu.sv
src/reg_file.sv
src/instr_decode.sv
src/exec_ctrl.sv
src/exec_top.sv
verif/exec_sva.sv
verif/exec_tb.sv

// ==== verif/exec_sva.sv ====
`timescale 1ns/1ps

module exec_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input logic [7:0] adr,
    input logic       ack
);

    ack_with_request: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb)
    ) else $error("ack without cyc and stb");

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ack |=> !ack
    ) else $error("ack high for two cycles");

    ack_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !ack
    ) else $error("ack high in the cycle after reset");

    // registered ack, seen one sample after the edge that raises it
    instr_ack_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($rose(cyc && stb) && we && (adr == riscv_pkg::addr_instr))
        |-> ##(riscv_pkg::ack_latency_instr) !ack ##1 ack
    ) else $error("instruction ack not at the fixed latency");

endmodule

bind exec_top exec_sva u_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .ack   (ack)
);

// ==== verif/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;

    logic                       clk;
    logic                       rst_n;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [7:0]                 adr;
    logic [riscv_pkg::xlen-1:0] dat_i;
    logic [3:0]                 sel;
    logic [riscv_pkg::xlen-1:0] dat_o;
    logic                       ack;

    logic [31:0]                lfsr_state = 32'd7941;
    logic [riscv_pkg::xlen-1:0] model_regs [0:riscv_pkg::reg_count-1];
    logic [riscv_pkg::xlen-1:0] exp_res;
    riscv_pkg::alu_flags_t      exp_flags;
    int                         cycle_count = 0;

    exec_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_i (dat_i),
        .sel   (sel),
        .dat_o (dat_o),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // traffic is about 11k cycles, limit leaves margin
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 20000) begin
            $display("timeout after %0d cycles, the run hung", cycle_count);
            fail_run("cycle limit reached");
        end
    end

    task automatic fail_run(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic logic [7:0] reg_addr(input logic [4:0] idx);
        return riscv_pkg::addr_reg_base | {1'b0, idx, 2'b00};
    endfunction

    task automatic check_word(input logic [riscv_pkg::xlen-1:0] got,
                              input logic [riscv_pkg::xlen-1:0] want, input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s read %08h, expected %08h", $time, what, got, want);
            fail_run("data mismatch");
        end
    endtask

    task automatic check_flags(input riscv_pkg::alu_flags_t got,
                               input riscv_pkg::alu_flags_t want, input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s read %05b, expected %05b (i n z c v)",
                     $time, what, got, want);
            fail_run("flag mismatch");
        end
    endtask

    // one classic cycle, ack expected on the given falling edge after the request
    task automatic bus_cycle(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, input int edges,
                             output logic [31:0] rdata);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_i = wdata;
        for (int n = 1; n <= edges; n++) begin
            @(negedge clk);
            if (ack && (n < edges)) begin
                $display("ack came %0d edges after the request to %02h, too early", n, addr);
                fail_run("early ack");
            end
        end
        if (!ack) begin
            $display("no ack %0d edges after the request to %02h at %0t ns", edges, addr, $time);
            fail_run("missing ack");
        end
        rdata = dat_o;
        // hold through the edge that samples ack
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        if (addr == riscv_pkg::addr_instr) begin
            bus_cycle(1'b1, addr, data, riscv_pkg::ack_latency_instr + 1, unused);
        end else begin
            bus_cycle(1'b1, addr, data, 2, unused);
        end
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, 2, data);
    endtask

    task automatic load_reg(input logic [4:0] idx, input logic [31:0] val);
        wb_write(reg_addr(idx), val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
        end
    endtask

    task automatic check_all_regs(input string what);
        logic [31:0] data;
        for (int i = 0; i < riscv_pkg::reg_count; i++) begin
            wb_read(reg_addr(i[4:0]), data);
            check_word(data, model_regs[i], $sformatf("%s x%0d", what, i));
        end
    endtask

    // reference model of one instruction
    task automatic model_execute(input logic [31:0] instr);
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic [31:0] r;
        logic        alt;
        logic        is_sub;
        logic        legal;
        opcode = instr[6:0];
        funct3 = instr[14:12];
        a      = model_regs[instr[19:15]];
        b      = model_regs[instr[24:20]];
        alt    = 1'b0;
        legal  = 1'b1;
        case (opcode)
            7'h33: alt = instr[30];
            7'h13: begin
                b   = {{20{instr[31]}}, instr[31:20]};
                alt = instr[30] && (funct3 == 3'd5);
                if (((funct3 == 3'd1) || (funct3 == 3'd5)) &&
                    (instr[31:25] != 7'h00) && (instr[31:25] != 7'h20)) begin
                    legal = 1'b0;
                end
            end
            7'h37: begin
                a      = '0;
                b      = {instr[31:12], 12'b0};
                funct3 = 3'd0;
            end
            default: legal = 1'b0;
        endcase
        is_sub = ((funct3 == 3'd0) && alt) || (funct3 == 3'd2) || (funct3 == 3'd3);
        if (is_sub) begin
            wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
        end else begin
            wide = {1'b0, a} + {1'b0, b};
        end
        case (funct3)
            3'd0: r = wide[31:0];
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        exp_flags = '0;
        if (!legal) begin
            exp_res           = '0;
            exp_flags.illegal = 1'b1;
        end else begin
            exp_res = r;
            if ((funct3 == 3'd0) || (funct3 == 3'd2) || (funct3 == 3'd3)) begin
                exp_flags.carry = wide[32];
            end
            if (funct3 == 3'd0) begin
                exp_flags.overflow = is_sub ? ((a[31] != b[31]) && (r[31] != a[31]))
                                            : ((a[31] == b[31]) && (r[31] != a[31]));
            end
            exp_flags.zero     = (r == '0);
            exp_flags.negative = r[31];
            if (instr[11:7] != 5'd0) begin
                model_regs[instr[11:7]] = r;
            end
        end
    endtask

    task automatic run_and_check(input logic [31:0] instr);
        logic [31:0] data;
        wb_write(riscv_pkg::addr_instr, instr);
        model_execute(instr);
        wb_read(reg_addr(instr[11:7]), data);
        check_word(data, model_regs[instr[11:7]], $sformatf("rd of %08h", instr));
        wb_read(riscv_pkg::addr_result, data);
        check_word(data, exp_res, $sformatf("result of %08h", instr));
        wb_read(riscv_pkg::addr_flags, data);
        check_word({data[31:5], 5'b0}, '0, "flags upper bits");
        check_flags(riscv_pkg::alu_flags_t'(data[4:0]), exp_flags,
                    $sformatf("flags of %08h", instr));
    endtask

    // x1 and x2 as operands, result in x3
    task automatic flag_case(input logic [31:0] instr, input logic [31:0] a,
                             input logic [31:0] b, input logic [4:0] want,
                             input string what);
        logic [31:0] data;
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        run_and_check(instr);
        wb_read(riscv_pkg::addr_flags, data);
        check_flags(riscv_pkg::alu_flags_t'(data[4:0]), riscv_pkg::alu_flags_t'(want), what);
    endtask

    initial begin
        logic [31:0] data;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  opcode;
        logic [4:0]  shamt;
        logic [1:0]  pick;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic [24:0] fill;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_i = '0;
        sel   = 4'hf;
        for (int i = 0; i < riscv_pkg::reg_count; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_all_regs("after reset");
        wb_read(riscv_pkg::addr_result, data);
        check_word(data, '0, "result after reset");
        wb_read(riscv_pkg::addr_flags, data);
        check_word(data, '0, "flags after reset");

        for (int i = 0; i < 64; i++) begin
            rd = rand_bits(5);
            load_reg(rd, rand_bits(32));
        end
        check_all_regs("random writes");

        // r-type, funct7 bit 5 only where it means something
        for (int i = 0; i < 200; i++) begin
            rs1    = rand_bits(5);
            rd     = rand_bits(5);
            funct3 = rand_bits(3);
            shamt  = rand_bits(5);
            load_reg(rs1, rand_bits(32));
            load_reg(shamt, rand_bits(32));
            pick[0] = ((funct3 == 3'd0) || (funct3 == 3'd5)) ? rand_bits(1) : 1'b0;
            run_and_check({1'b0, pick[0], 5'b0, shamt, rs1, funct3, rd, 7'h33});
        end

        for (int i = 0; i < 150; i++) begin
            rd     = rand_bits(5);
            rs1    = rand_bits(5);
            funct3 = rand_bits(3);
            if (rand_bits(3) == 0) begin
                upper = rand_bits(20);
                run_and_check({upper, rd, 7'h37});
            end else begin
                load_reg(rs1, rand_bits(32));
                if ((funct3 == 3'd1) || (funct3 == 3'd5)) begin
                    pick  = rand_bits(2);
                    shamt = (pick == 2'd0) ? 5'd0 : (pick == 2'd1) ? 5'd31 : rand_bits(5);
                    data[6:0] = ((funct3 == 3'd5) && rand_bits(1)) ? 7'h20 : 7'h00;
                    run_and_check({data[6:0], shamt, rs1, funct3, rd, 7'h13});
                end else begin
                    imm12 = rand_bits(12);
                    run_and_check({imm12, rs1, funct3, rd, 7'h13});
                end
            end
        end

        flag_case(32'h0020_81b3, 32'h7fff_ffff, 32'h1, 5'b01001, "add overflow");
        flag_case(32'h0020_81b3, 32'hffff_ffff, 32'h1, 5'b00110, "add carry to zero");
        flag_case(32'h4020_81b3, 32'h8000_0000, 32'h1, 5'b00011, "sub overflow");
        flag_case(32'h0020_a1b3, 32'hffff_ffff, 32'h1, 5'b00010, "slt -1 < 1");
        flag_case(32'h0020_b1b3, 32'hffff_ffff, 32'h1, 5'b00110, "sltu big vs 1");
        flag_case(32'h0020_a1b3, 32'h1, 32'h8000_0000, 5'b00100, "slt 1 vs min");
        flag_case(32'h0020_b1b3, 32'h1, 32'h8000_0000, 5'b00000, "sltu 1 vs min");

        for (int i = 0; i < 12; i++) begin
            if ((i % 3) == 2) begin
                // shift immediate with a bad funct7
                data[6:0] = rand_bits(7) | 7'h01;
                shamt     = rand_bits(5);
                rs1       = rand_bits(5);
                rd        = rand_bits(5);
                run_and_check({data[6:0], shamt, rs1, 3'd5, rd, 7'h13});
            end else begin
                opcode = rand_bits(7);
                while ((opcode == 7'h33) || (opcode == 7'h13) || (opcode == 7'h37)) begin
                    opcode = rand_bits(7);
                end
                fill = rand_bits(25);
                run_and_check({fill, opcode});
            end
            check_all_regs("after illegal");
            imm12 = rand_bits(12);
            rs1   = rand_bits(5);
            rd    = rand_bits(5);
            run_and_check({imm12, rs1, 3'd0, rd, 7'h13});
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
